//--- rram_ctrl_pkg.sv
package rram_ctrl_pkg;

    // Crossbar tile geometry
    localparam int NUM_ROWS       = 16;     // Word lines
    localparam int NUM_COLS       = 128;    // Bit-line columns
    localparam int NUM_ADC        = 8;      // Shared ADCs along the tile edge
    localparam int MUX_RATIO      = 16;     // Columns behind each ADC
    localparam int ADC_WIDTH      = 4;
    localparam int DATA_WIDTH     = 64;     // Data FIFO and output FIFO word
    localparam int INSTR_WIDTH    = 4;
    localparam int OPCODE_WIDTH   = 16;
    localparam int WRITE_CYCLES   = 8;      // Length of one write polarity phase
    localparam int WORDS_PER_HALF = 4;      // 64 columns x 4b codes = 4 words

    // Derived widths
    localparam int ROW_ADDR_W  = $clog2(NUM_ROWS);
    localparam int MUX_SEL_W   = $clog2(MUX_RATIO);
    localparam int NUM_WORDS_W = $clog2(2*WORDS_PER_HALF+1);
    localparam int WORD_IDX_W  = $clog2(2*WORDS_PER_HALF);

    // Instruction codes
    localparam logic [INSTR_WIDTH-1:0] INSTR_STORE_RRAM = 4'd0;
    localparam logic [INSTR_WIDTH-1:0] INSTR_READ_RRAM  = 4'd1;

    // Bit-line drive, {minus, plus}
    localparam logic [1:0] BL_IDLE  = 2'b00;
    localparam logic [1:0] BL_PLUS  = 2'b01;
    localparam logic [1:0] BL_MINUS = 2'b10;

    typedef struct packed {
        logic [OPCODE_WIDTH-ROW_ADDR_W-3:0] unused;
        logic                               burst;  // Both halves, wraps from selected half
        logic                               half;   // 0 = cols 0..63, 1 = cols 64..127
        logic [ROW_ADDR_W-1:0]              row;
    } rram_op_t;

    typedef struct packed {
        logic [INSTR_WIDTH-1:0] instr;
        rram_op_t               op;
    } rram_instr_t;

    typedef logic [NUM_ADC-1:0][ADC_WIDTH-1:0] adc_codes_t;

    typedef struct packed {
        logic [NUM_ROWS-1:0]      wl_sel;       // One-hot row select
        logic [NUM_COLS-1:0][1:0] bl_sel;       // Per column {minus, plus}
        logic [MUX_SEL_W-1:0]     sl_mux_sel;
        logic                     wl_bias;      // 1 = write bias
        logic                     bl_bias;      // 1 = write bias
    } array_ctrl_t;

    typedef struct packed {
        logic                  load;        // Take data_dout into weight register
        logic                  load_half;
        logic                  prog;        // Write phase active
        logic                  polarity;    // 0 = positive phase, 1 = negative phase
        logic                  read;
        logic [ROW_ADDR_W-1:0] row;
        logic [MUX_SEL_W-1:0]  mux_step;
    } drive_cmd_t;

    typedef struct packed {
        logic                   capture;
        logic [MUX_SEL_W-1:0]   mux_step;
        logic                   start_drain;
        logic                   first_half;
        logic [NUM_WORDS_W-1:0] num_words;  // 4 or 8
    } scan_cmd_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_FETCH,
        ST_WRITE_POS,
        ST_WRITE_NEG,
        ST_SCAN,
        ST_DRAIN
    } seq_state_t;

endpackage

//--- rram_seq_fsm.sv
`timescale 1ns/10ps

module rram_seq_fsm (
    input  logic                       CLK,
    input  logic                       rst_n,
    input  rram_ctrl_pkg::rram_instr_t instr_dout,
    input  logic                       instr_empty,
    input  logic                       data_empty,
    input  logic                       drain_done,     // One-cycle pulse from readout
    output logic                       instr_pop,
    output logic                       data_pop,
    output rram_ctrl_pkg::drive_cmd_t  drive,
    output rram_ctrl_pkg::scan_cmd_t   scan
);

    import rram_ctrl_pkg::*;

    seq_state_t           state_q;
    rram_op_t             op_q;         // Operand of the instruction in flight
    logic [MUX_SEL_W-1:0] cnt_q;        // Write cycle or mux step
    logic                 word_q;       // Second word of a burst store
    logic                 phase_end;
    logic                 scan_end;

    assign phase_end = (cnt_q == MUX_SEL_W'(WRITE_CYCLES-1));
    assign scan_end  = (cnt_q == MUX_SEL_W'(MUX_RATIO-1));

    // FIFO pops go out in the cycle the entry is consumed
    assign instr_pop = (state_q == ST_IDLE) && !instr_empty;
    assign data_pop  = (state_q == ST_FETCH) && !data_empty;

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            state_q <= ST_IDLE;
            cnt_q   <= '0;
            word_q  <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    cnt_q  <= '0;
                    word_q <= 1'b0;
                    if (!instr_empty) begin
                        case (instr_dout.instr)
                            INSTR_STORE_RRAM: state_q <= ST_FETCH;
                            INSTR_READ_RRAM:  state_q <= ST_SCAN;
                            default:          state_q <= ST_IDLE;  // Unknown code is dropped
                        endcase
                    end
                end
                ST_FETCH: begin
                    if (!data_empty) begin  // Word is loaded on this edge
                        state_q <= ST_WRITE_POS;
                        cnt_q   <= '0;
                    end
                end
                ST_WRITE_POS: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (phase_end) begin
                        state_q <= ST_WRITE_NEG;
                        cnt_q   <= '0;
                    end
                end
                ST_WRITE_NEG: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (phase_end) begin
                        cnt_q <= '0;
                        if (op_q.burst && !word_q) begin
                            word_q  <= 1'b1;    // Other half next
                            state_q <= ST_FETCH;
                        end else begin
                            state_q <= ST_IDLE;
                        end
                    end
                end
                ST_SCAN: begin
                    cnt_q <= cnt_q + 1'b1;      // Wraps to 0 after step 15
                    if (scan_end)
                        state_q <= ST_DRAIN;
                end
                ST_DRAIN: begin
                    if (drain_done)
                        state_q <= ST_IDLE;
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // Operand of the popped instruction, held until the next pop
    always_ff @(posedge CLK) begin
        if (instr_pop)
            op_q <= instr_dout.op;
    end

    always_comb begin
        drive.load      = data_pop;
        drive.load_half = op_q.half ^ word_q;
        drive.prog      = (state_q == ST_WRITE_POS) || (state_q == ST_WRITE_NEG);
        drive.polarity  = (state_q == ST_WRITE_NEG);
        drive.read      = (state_q == ST_SCAN);
        drive.row       = op_q.row;
        drive.mux_step  = cnt_q;

        scan.capture     = (state_q == ST_SCAN);
        scan.mux_step    = cnt_q;
        scan.start_drain = (state_q == ST_SCAN) && scan_end;   // Last capture edge
        scan.first_half  = op_q.half;
        scan.num_words   = op_q.burst ? NUM_WORDS_W'(2*WORDS_PER_HALF)
                                      : NUM_WORDS_W'(WORDS_PER_HALF);
    end

endmodule

//--- rram_array_driver.sv
`timescale 1ns/10ps

module rram_array_driver (
    input  logic                                 CLK,
    input  logic                                 rst_n,
    input  rram_ctrl_pkg::drive_cmd_t            drive,
    input  logic [rram_ctrl_pkg::DATA_WIDTH-1:0] data_dout,
    output rram_ctrl_pkg::array_ctrl_t           array_ctrl
);

    import rram_ctrl_pkg::*;

    logic [NUM_COLS-1:0] weight_q;  // Target conductance state per column
    logic [NUM_COLS-1:0] col_en_q;  // Columns taking part in programming

    // Weight register, one half per load
    always_ff @(posedge CLK) begin
        if (drive.load)
            weight_q[{drive.load_half, 6'b0} +: DATA_WIDTH] <= data_dout;
    end

    // Column enable follows the last loaded half only
    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            col_en_q <= '0;
        end else if (drive.load) begin
            for (int c = 0; c < NUM_COLS; c++)
                col_en_q[c] <= ((c >= DATA_WIDTH) == drive.load_half);
        end
    end

    always_comb begin
        array_ctrl.wl_sel     = '0;
        array_ctrl.sl_mux_sel = '0;
        array_ctrl.wl_bias    = 1'b0;     // Read bias
        array_ctrl.bl_bias    = 1'b0;
        for (int c = 0; c < NUM_COLS; c++)
            array_ctrl.bl_sel[c] = BL_IDLE;

        if (drive.prog) begin
            array_ctrl.wl_sel[drive.row] = 1'b1;
            array_ctrl.wl_bias           = 1'b1;
            array_ctrl.bl_bias           = 1'b1;
            for (int c = 0; c < NUM_COLS; c++) begin
                if (col_en_q[c]) begin
                    if (!drive.polarity && weight_q[c])
                        array_ctrl.bl_sel[c] = BL_PLUS;     // SET cells holding 1
                    else if (drive.polarity && !weight_q[c])
                        array_ctrl.bl_sel[c] = BL_MINUS;    // RESET cells holding 0
                end
            end
        end else if (drive.read) begin
            array_ctrl.wl_sel[drive.row] = 1'b1;
            array_ctrl.sl_mux_sel        = drive.mux_step;  // Not registered, same-cycle mux
            // One column per ADC group is biased
            for (int a = 0; a < NUM_ADC; a++)
                array_ctrl.bl_sel[a*MUX_RATIO + int'(drive.mux_step)] = BL_PLUS;
        end
    end

endmodule

//--- rram_adc_readout.sv
`timescale 1ns/10ps

module rram_adc_readout (
    input  logic                                 CLK,
    input  logic                                 rst_n,
    input  rram_ctrl_pkg::scan_cmd_t             scan,
    input  rram_ctrl_pkg::adc_codes_t            adc_codes,
    input  logic                                 out_full,
    output logic                                 out_push,
    output logic [rram_ctrl_pkg::DATA_WIDTH-1:0] out_din,
    output logic                                 drain_done
);

    import rram_ctrl_pkg::*;

    logic [NUM_COLS-1:0][ADC_WIDTH-1:0] code_buf;   // One code per column
    logic                               draining_q;
    logic [WORD_IDX_W-1:0]              word_idx_q;
    logic                               first_half_q;
    logic [NUM_WORDS_W-1:0]             num_words_q;
    logic                               done_q;
    logic                               word_half;
    logic [6:0]                         word_base;   // First column of current word
    logic                               last_word;

    // Column c sits behind ADC c/16 at mux step c%16
    always_ff @(posedge CLK) begin
        if (scan.capture) begin
            for (int a = 0; a < NUM_ADC; a++)
                code_buf[a*MUX_RATIO + int'(scan.mux_step)] <= adc_codes[a];
        end
    end

    // Upper index bit moves to the other half on a burst
    assign word_half = first_half_q ^ word_idx_q[WORD_IDX_W-1];
    assign word_base = {word_half, word_idx_q[WORD_IDX_W-2:0], 4'b0000};
    assign last_word = ({1'b0, word_idx_q} == num_words_q - NUM_WORDS_W'(1));

    assign out_din    = code_buf[word_base +: DATA_WIDTH/ADC_WIDTH];  // Lowest column in low nibble
    assign out_push   = draining_q && !out_full;     // Word held while full
    assign drain_done = done_q;

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            draining_q <= 1'b0;
            word_idx_q <= '0;
            done_q     <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (scan.start_drain) begin
                draining_q <= 1'b1;
                word_idx_q <= '0;
            end else if (out_push) begin
                word_idx_q <= word_idx_q + 1'b1;
                if (last_word) begin
                    draining_q <= 1'b0;
                    done_q     <= 1'b1;  // Pulse in the cycle after the last push
                end
            end
        end
    end

    // Drain parameters, taken with the start
    always_ff @(posedge CLK) begin
        if (scan.start_drain) begin
            first_half_q <= scan.first_half;
            num_words_q  <= scan.num_words;
        end
    end

endmodule

//--- rram_ctrl_top.sv
`timescale 1ns/10ps

module rram_ctrl_top (
    input  logic                                CLK,
    input  logic                                rst_n,
    // Instruction FIFO, show-ahead
    input  rram_ctrl_pkg::rram_instr_t          instr_dout,
    input  logic                                instr_empty,
    output logic                                instr_pop,
    // Input data FIFO, show-ahead
    input  logic [rram_ctrl_pkg::DATA_WIDTH-1:0] data_dout,
    input  logic                                data_empty,
    output logic                                data_pop,
    // Output FIFO
    input  logic                                out_full,
    output logic                                out_push,
    output logic [rram_ctrl_pkg::DATA_WIDTH-1:0] out_din,
    // Crossbar
    input  rram_ctrl_pkg::adc_codes_t           adc_codes,
    output rram_ctrl_pkg::array_ctrl_t          array_ctrl
);

    import rram_ctrl_pkg::*;

    drive_cmd_t drive;      // Sequencer to array driver
    scan_cmd_t  scan;       // Sequencer to ADC readout
    logic       drain_done;

    rram_seq_fsm rram_seq_fsm_i (
        .CLK         (CLK),
        .rst_n       (rst_n),
        .instr_dout  (instr_dout),
        .instr_empty (instr_empty),
        .data_empty  (data_empty),
        .drain_done  (drain_done),
        .instr_pop   (instr_pop),
        .data_pop    (data_pop),
        .drive       (drive),
        .scan        (scan)
    );

    rram_array_driver rram_array_driver_i (
        .CLK        (CLK),
        .rst_n      (rst_n),
        .drive      (drive),
        .data_dout  (data_dout),
        .array_ctrl (array_ctrl)
    );

    rram_adc_readout rram_adc_readout_i (
        .CLK        (CLK),
        .rst_n      (rst_n),
        .scan       (scan),
        .adc_codes  (adc_codes),
        .out_full   (out_full),
        .out_push   (out_push),
        .out_din    (out_din),
        .drain_done (drain_done)
    );

endmodule

//--- tb_clock.sv
`timescale 1ns/10ps

module tb_clock (
    output logic CLK,
    output logic rst_n
);

    localparam int HALF_PERIOD  = 10;   // 20 ns clock
    localparam int RESET_CYCLES = 4;

    initial begin
        CLK = 1'b0;
        forever #(HALF_PERIOD) CLK = ~CLK;
    end

    // Reset released just after a rising edge, like any other input
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge CLK);
        #1;
        rst_n = 1'b1;
    end

endmodule

//--- tb_rram_tasks.svh
`ifndef TB_RRAM_TASKS_SVH
`define TB_RRAM_TASKS_SVH

task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Errors found");
    $fatal(1, "simulation stopped");
endtask

task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                           input string what);
    if (actual !== expected) begin
        $display("Fail at %0t: %s, got %h, expected %h", $time, what, actual, expected);
        $display("Errors found");
        $fatal(1, "simulation stopped");
    end
endtask

function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
endfunction

function automatic logic [63:0] random_word();
    logic [63:0] w;
    w[63:32] = lcg_next();
    w[31:0]  = lcg_next();
    return w;
endfunction

function automatic rram_instr_t make_instr(input logic [INSTR_WIDTH-1:0] code, input int row,
                                           input logic half, input logic burst);
    rram_instr_t ins;
    ins          = '0;
    ins.instr    = code;
    ins.op.row   = 4'(row);
    ins.op.half  = half;
    ins.op.burst = burst;
    return ins;
endfunction

// Word w of a half holds 16 columns with the lowest column in the low nibble
function automatic logic [63:0] expected_word(input int row, input int half, input int w);
    logic [63:0] word;
    int          col;
    word = '0;
    for (int j = 0; j < 16; j++) begin
        col = half*64 + w*16 + j;
        word[j*4 +: 4] = exp_cells[row][col] ? CODE_ONE : CODE_ZERO;
    end
    return word;
endfunction

// Columns whose bit-line select differs from a read at this mux step
function automatic int count_bl_mismatches(input int step);
    int         errors;
    logic [1:0] want;
    errors = 0;
    for (int c = 0; c < NUM_COLS; c++) begin
        want = (c % MUX_RATIO == step) ? 2'b01 : 2'b00;    // Plus on one column per ADC
        if (array_ctrl.bl_sel[c] !== want)
            errors++;
    end
    return errors;
endfunction

// Stores one word or two for a burst with data that can show up late
task automatic store_words(input int row, input logic half, input logic burst,
                           input logic [63:0] w0, input logic [63:0] w1, input int data_delay);
    logic [63:0] words [2];
    int          nw;
    int          bias_cycles;
    int          h;
    words[0] = w0;
    words[1] = w1;
    nw       = burst ? 2 : 1;
    @(negedge CLK);
    instr_q.push_back(make_instr(INSTR_STORE_RRAM, row, half, burst));
    repeat (data_delay) begin
        @(negedge CLK);
        check_value(64'(array_ctrl.wl_bias), 64'd0, "write bias before data arrived");
    end
    for (int i = 0; i < nw; i++)
        data_q.push_back(words[i]);
    for (int i = 0; i < nw; i++) begin
        while (!data_pop) @(negedge CLK);     // Pop cycle with the load on the next edge
        bias_cycles = 0;
        @(negedge CLK);
        while (array_ctrl.wl_bias) begin
            check_value(64'(array_ctrl.wl_sel), 64'(1) << row, "word line during write");
            check_value(64'(array_ctrl.bl_bias), 64'd1, "bit-line bias during write");
            bias_cycles++;
            @(negedge CLK);
        end
        check_value(64'(bias_cycles), 64'(2*WRITE_CYCLES), "write phase length");
        h = int'(half) ^ i;                   // Burst wraps to the other half
        exp_cells[row][h*DATA_WIDTH +: DATA_WIDTH] = words[i];
    end
endtask

// Read and compare with optional random back-pressure on the output FIFO
task automatic read_check(input int row, input logic half, input logic burst,
                          input logic stall);
    int          nw;
    int          scan_steps;
    int          h;
    logic [31:0] r;
    nw         = burst ? 2*WORDS_PER_HALF : WORDS_PER_HALF;
    scan_steps = 0;
    @(negedge CLK);
    out_q.delete();
    instr_q.push_back(make_instr(INSTR_READ_RRAM, row, half, burst));
    while (out_q.size() < nw) begin
        @(posedge CLK);
        #1;
        r        = lcg_next();
        out_full = stall && (r[17:16] != 2'b00);    // Full about 3 cycles in 4
        @(negedge CLK);
        if (array_ctrl.wl_sel != '0 && !array_ctrl.wl_bias) begin
            check_value(64'(array_ctrl.wl_sel), 64'(1) << row, "word line during scan");
            check_value(64'(array_ctrl.bl_bias), 64'd0, "bit-line bias during scan");
            check_value(64'(array_ctrl.sl_mux_sel), 64'(scan_steps), "mux step");
            check_value(64'(count_bl_mismatches(scan_steps)), 64'd0,
                        "bit-line select during scan");
            scan_steps++;
        end
    end
    @(posedge CLK);
    #1;
    out_full = 1'b0;
    repeat (4) @(negedge CLK);                  // Room for a stray extra word
    check_value(64'(scan_steps), 64'(MUX_RATIO), "scan length");
    check_value(64'(out_q.size()), 64'(nw), "output word count");
    for (int k = 0; k < nw; k++) begin
        h = int'(half) ^ (k / WORDS_PER_HALF);
        check_value(out_q[k], expected_word(row, h, k % WORDS_PER_HALF),
                    $sformatf("row %0d output word %0d", row, k));
    end
endtask

task automatic test_reset_state();
    @(negedge CLK);
    check_value(64'(instr_pop), 64'd0, "instr_pop after reset");
    check_value(64'(data_pop), 64'd0, "data_pop after reset");
    check_value(64'(out_push), 64'd0, "out_push after reset");
    check_value(64'(array_ctrl.wl_sel), 64'd0, "wl_sel after reset");
    check_value(64'(array_ctrl.bl_sel != '0), 64'd0, "bl_sel idle after reset");
    check_value(64'(array_ctrl.wl_bias), 64'd0, "wl_bias after reset");
    check_value(64'(array_ctrl.bl_bias), 64'd0, "bl_bias after reset");
endtask

task automatic test_single_store_read();
    store_words(5, 1'b0, 1'b0, random_word(), '0, 0);
    read_check(5, 1'b0, 1'b0, 1'b0);
endtask

task automatic test_burst();
    store_words(9, 1'b1, 1'b1, random_word(), random_word(), 0);
    read_check(9, 1'b1, 1'b1, 1'b0);        // Half 1 comes out first
endtask

task automatic test_row_isolation();
    read_check(12, 1'b0, 1'b1, 1'b0);       // Never written
    read_check(5, 1'b0, 1'b1, 1'b0);        // Untouched by the row 9 store
    store_words(5, 1'b1, 1'b0, random_word(), '0, 0);
    read_check(5, 1'b0, 1'b1, 1'b0);        // Half 0 kept by the column mask
endtask

task automatic test_back_pressure();
    store_words(5, 1'b0, 1'b0, random_word(), '0, 12);     // Overwrite with late data
    read_check(5, 1'b0, 1'b1, 1'b1);
    read_check(9, 1'b1, 1'b1, 1'b1);
endtask

`endif

//--- tb_rram_ctrl.sv
`timescale 1ns/10ps

module tb_rram_ctrl;

    import rram_ctrl_pkg::*;

    localparam int TIMEOUT_CYCLES = 2000;           // About 5x the summed test lengths
    localparam logic [ADC_WIDTH-1:0] CODE_ONE  = 4'hC;
    localparam logic [ADC_WIDTH-1:0] CODE_ZERO = 4'h3;

    logic                  CLK;
    logic                  rst_n;
    rram_instr_t           instr_dout;
    logic                  instr_empty;
    logic                  instr_pop;
    logic [DATA_WIDTH-1:0] data_dout;
    logic                  data_empty;
    logic                  data_pop;
    logic                  out_full;
    logic                  out_push;
    logic [DATA_WIDTH-1:0] out_din;
    adc_codes_t            adc_codes;
    array_ctrl_t           array_ctrl;

    // FIFO models with the queue head as the show-ahead word
    rram_instr_t           instr_q[$];
    logic [DATA_WIDTH-1:0] data_q[$];
    logic [DATA_WIDTH-1:0] out_q[$];

    // DUT outputs as seen on the falling edge
    logic                  instr_pop_s = 1'b0;
    logic                  data_pop_s  = 1'b0;
    logic                  out_push_s  = 1'b0;
    logic [DATA_WIDTH-1:0] out_din_s;
    array_ctrl_t           ctrl_s;

    logic [NUM_ROWS-1:0][NUM_COLS-1:0] cells;       // Crossbar model state
    logic [NUM_ROWS-1:0][NUM_COLS-1:0] exp_cells;   // What the stores should leave behind
    logic [31:0]                       lcg_state;
    int                                cycle_cnt = 0;
    int                                read_row;

    tb_clock tb_clock_i (
        .CLK   (CLK),
        .rst_n (rst_n)
    );

    rram_ctrl_top rram_ctrl_top_i (
        .CLK         (CLK),
        .rst_n       (rst_n),
        .instr_dout  (instr_dout),
        .instr_empty (instr_empty),
        .instr_pop   (instr_pop),
        .data_dout   (data_dout),
        .data_empty  (data_empty),
        .data_pop    (data_pop),
        .out_full    (out_full),
        .out_push    (out_push),
        .out_din     (out_din),
        .adc_codes   (adc_codes),
        .array_ctrl  (array_ctrl)
    );

    `include "tb_rram_tasks.svh"

    // Crossbar read path with one column per ADC picked by the mux
    always_comb begin
        adc_codes = '0;
        read_row  = 0;
        for (int r = 0; r < NUM_ROWS; r++)
            if (array_ctrl.wl_sel[r])
                read_row = r;
        if (!array_ctrl.wl_bias && array_ctrl.wl_sel != '0) begin
            for (int a = 0; a < NUM_ADC; a++)
                adc_codes[a] = cells[read_row][a*MUX_RATIO + int'(array_ctrl.sl_mux_sel)]
                               ? CODE_ONE : CODE_ZERO;
        end
    end

    always @(negedge CLK) begin
        instr_pop_s = instr_pop;
        data_pop_s  = data_pop;
        out_push_s  = out_push;
        out_din_s   = out_din;
        ctrl_s      = array_ctrl;
        if (rst_n)
            check_value(64'(out_push && out_full), 64'd0, "push while output FIFO full");
    end

    // FIFO and cell updates for the edge just passed
    always @(posedge CLK) begin
        #1;
        if (instr_pop_s) begin
            if (instr_q.size() == 0)
                report_failure("Instruction FIFO was popped while empty");
            else
                void'(instr_q.pop_front());
        end
        if (data_pop_s) begin
            if (data_q.size() == 0)
                report_failure("Data FIFO was popped while empty");
            else
                void'(data_q.pop_front());
        end
        if (out_push_s)
            out_q.push_back(out_din_s);
        if (ctrl_s.wl_bias) begin
            for (int r = 0; r < NUM_ROWS; r++) begin
                if (ctrl_s.wl_sel[r]) begin
                    for (int c = 0; c < NUM_COLS; c++) begin
                        if (ctrl_s.bl_sel[c] == 2'b01)          // Plus sets
                            cells[r][c] = 1'b1;
                        else if (ctrl_s.bl_sel[c] == 2'b10)     // Minus resets
                            cells[r][c] = 1'b0;
                    end
                end
            end
        end
        instr_empty = (instr_q.size() == 0);
        instr_dout  = instr_empty ? '0 : instr_q[0];
        data_empty  = (data_q.size() == 0);
        data_dout   = data_empty ? '0 : data_q[0];
    end

    always @(posedge CLK) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > TIMEOUT_CYCLES)
            report_failure($sformatf("Timeout, run went past %0d cycles", TIMEOUT_CYCLES));
    end

    initial begin
        instr_dout  = '0;
        instr_empty = 1'b1;
        data_dout   = '0;
        data_empty  = 1'b1;
        out_full    = 1'b0;
        cells       = '0;       // Fresh array with all cells at 0
        exp_cells   = '0;
        lcg_state   = 32'd3;
        do @(negedge CLK); while (rst_n !== 1'b1);
        test_reset_state();
        test_single_store_read();
        test_burst();
        test_row_isolation();
        test_back_pressure();
        $display("No errors");
        $finish;
    end

endmodule

//--- rram_ctrl_top.f
+incdir+.
rram_ctrl_pkg.sv
rram_seq_fsm.sv
rram_array_driver.sv
rram_adc_readout.sv
rram_ctrl_top.sv
tb_clock.sv
tb_rram_ctrl.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_rram_ctrl
FILELIST  ?= rram_ctrl_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
